/* src/cp0_pkg.sv */
package cp0_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  cp0_addr_t;
    typedef logic [4:0]  exccode_t;

    typedef struct packed {
        logic [8:0] zero_31_23;
        logic       bev;
        logic [5:0] zero_21_16;
        logic [7:0] im;
        logic [4:0] zero_7_3;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic        bd;
        logic [14:0] zero_30_16;
        logic [7:0]  ip;
        logic        zero_7;
        exccode_t    exccode;
        logic [1:0]  zero_1_0;
    } cause_t;

    // config is a keyword, hence the trailing underscore
    typedef struct packed {
        word_t   badvaddr;
        word_t   count;
        word_t   compare;
        status_t status;
        cause_t  cause;
        word_t   epc;
        word_t   config_;
    } cp0_regs_t;

endpackage

/* src/cp0_regs.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module cp0_regs (
    input  logic                clk,
    input  logic                reset,

    input  cp0_pkg::cp0_addr_t  rd_addr,
    output cp0_pkg::word_t      rd_data,

    input  logic                we,
    input  cp0_pkg::cp0_addr_t  wa,
    input  cp0_pkg::word_t      wd,

    input  exc_pkg::exception_t exception,
    input  logic                eret,

    input  logic [5:0]          hw_int,

    output cp0_pkg::cp0_regs_t  cp0,
    output logic                int_pending
);

    cp0_pkg::cp0_regs_t cp0_next;
    logic               count_tick;
    logic [5:0]         hw_sync;
    logic               timer_q;
    logic               timer_next;
    logic               compare_wr;

    // first sync stage, cause.ip[7:2] is the second
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            hw_sync <= '0;
        end else begin
            hw_sync <= hw_int;
        end
    end

    // count advances every other clock
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count_tick <= 1'b0;
        end else begin
            count_tick <= ~count_tick;
        end
    end

    assign compare_wr = we && (wa == `CP0_COMPARE);

    // sticky until compare is written again
    always_comb begin
        timer_next = timer_q | (cp0.count == cp0.compare);
        if (compare_wr) begin
            timer_next = 1'b0;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            timer_q <= 1'b0;
        end else begin
            timer_q <= timer_next;
        end
    end

    always_comb begin
        cp0_next = cp0;

        if (count_tick) begin
            cp0_next.count = cp0.count + 32'd1;
        end

        if (we) begin
            case (wa)
                `CP0_COUNT:   cp0_next.count = wd;
                `CP0_COMPARE: cp0_next.compare = wd;
                `CP0_STATUS: begin
                    cp0_next.status.im  = wd[15:8];
                    cp0_next.status.exl = wd[1];
                    cp0_next.status.ie  = wd[0];
                end
                `CP0_CAUSE:   cp0_next.cause.ip[1:0] = wd[9:8];
                `CP0_EPC:     cp0_next.epc = wd;
                default: ;
            endcase
        end

        if (exception.valid) begin
            // nested exception keeps the original return point
            if (!cp0.status.exl) begin
                cp0_next.cause.bd = exception.in_delay_slot;
                cp0_next.epc = exception.in_delay_slot ? exception.pc - 32'd4
                                                       : exception.pc;
            end
            cp0_next.status.exl = 1'b1;
            cp0_next.cause.exccode = exception.code;
            if (exception.code == `CODE_ADEL || exception.code == `CODE_ADES) begin
                cp0_next.badvaddr = exception.badvaddr;
            end
        end

        if (eret) begin
            if (cp0.status.erl) begin
                cp0_next.status.erl = 1'b0;
            end else begin
                cp0_next.status.exl = 1'b0;
            end
        end

        // hw interrupt 5 shares ip[7] with the timer
        cp0_next.cause.ip[7:2] = {hw_sync[5] | timer_next, hw_sync[4:0]};
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            cp0 <= '{badvaddr: '0,
                     count:    '0,
                     compare:  `COMPARE_RESET,
                     status:   `STATUS_RESET,
                     cause:    '0,
                     epc:      '0,
                     config_:  `CONFIG_RESET};
        end else begin
            cp0 <= cp0_next;
        end
    end

    always_comb begin
        case (rd_addr)
            `CP0_BADVADDR: rd_data = cp0.badvaddr;
            `CP0_COUNT:    rd_data = cp0.count;
            `CP0_COMPARE:  rd_data = cp0.compare;
            `CP0_STATUS:   rd_data = cp0.status;
            `CP0_CAUSE:    rd_data = cp0.cause;
            `CP0_EPC:      rd_data = cp0.epc;
            `CP0_CONFIG:   rd_data = cp0.config_;
            default:       rd_data = '0;
        endcase
    end

    assign int_pending = cp0.status.ie && !cp0.status.exl && !cp0.status.erl
                         && |(cp0.status.im & cp0.cause.ip);

endmodule

/* src/cp0_subsys.sv */
`timescale 1ns/1ps

module cp0_subsys (
    input  logic               clk,
    input  logic               reset,

    input  logic               commit_valid,
    output logic               commit_ready,
    input  exc_pkg::commit_t   commit,

    input  logic [5:0]         hw_int,

    input  cp0_pkg::cp0_addr_t rd_addr,
    output cp0_pkg::word_t     rd_data,

    output exc_pkg::redirect_t redirect,
    output logic               timer_irq
);

    exc_pkg::exception_t exception;
    logic                eret_take;
    logic                cp0_we;
    cp0_pkg::cp0_addr_t  cp0_wa;
    cp0_pkg::word_t      cp0_wd;
    cp0_pkg::cp0_regs_t  cp0;
    logic                int_pending;

    exc_unit u_exc_unit (
        .clk          (clk),
        .reset        (reset),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit),
        .cp0          (cp0),
        .int_pending  (int_pending),
        .exception    (exception),
        .eret_take    (eret_take),
        .cp0_we       (cp0_we),
        .cp0_wa       (cp0_wa),
        .cp0_wd       (cp0_wd),
        .redirect     (redirect)
    );

    cp0_regs u_cp0_regs (
        .clk         (clk),
        .reset       (reset),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .we          (cp0_we),
        .wa          (cp0_wa),
        .wd          (cp0_wd),
        .exception   (exception),
        .eret        (eret_take),
        .hw_int      (hw_int),
        .cp0         (cp0),
        .int_pending (int_pending)
    );

    // also the wake-up source for wait
    assign timer_irq = cp0.cause.ip[7];

endmodule

/* src/exc_pkg.sv */
package exc_pkg;

    typedef enum logic [2:0] {
        normal   = 3'd0,
        load     = 3'd1,
        store    = 3'd2,
        syscall  = 3'd3,
        break_op = 3'd4,
        eret     = 3'd5,
        mtc0     = 3'd6,
        reserved = 3'd7
    } instr_kind_t;

    // 0 byte, 1 half, 2 word
    typedef logic [1:0] mem_size_t;

    typedef struct packed {
        cp0_pkg::word_t     pc;
        logic               in_delay_slot;
        instr_kind_t        kind;
        cp0_pkg::word_t     mem_addr;
        mem_size_t          mem_size;
        logic               overflow;
        cp0_pkg::cp0_addr_t cp0_addr;
        cp0_pkg::word_t     wdata;
    } commit_t;

    typedef struct packed {
        logic              valid;
        cp0_pkg::exccode_t code;
        cp0_pkg::word_t    pc;
        logic              in_delay_slot;
        cp0_pkg::word_t    badvaddr;
    } exception_t;

    typedef struct packed {
        logic           valid;
        cp0_pkg::word_t target;
    } redirect_t;

endpackage

/* src/exc_unit.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module exc_unit (
    input  logic                clk,
    input  logic                reset,

    input  logic                commit_valid,
    output logic                commit_ready,
    input  exc_pkg::commit_t    commit,

    input  cp0_pkg::cp0_regs_t  cp0,
    input  logic                int_pending,

    output exc_pkg::exception_t exception,
    output logic                eret_take,
    output logic                cp0_we,
    output cp0_pkg::cp0_addr_t  cp0_wa,
    output cp0_pkg::word_t      cp0_wd,

    output exc_pkg::redirect_t  redirect
);

    logic              fire;
    logic              pc_misaligned;
    logic              data_misaligned;
    logic              is_mem;
    logic              exc_hit;
    cp0_pkg::exccode_t exc_code;
    cp0_pkg::word_t    exc_badvaddr;
    logic              redirect_take;
    logic              ready_q;
    logic              redirect_valid_q;
    cp0_pkg::word_t    redirect_target_q;

    assign fire = commit_valid && commit_ready;

    assign pc_misaligned = commit.pc[1:0] != 2'b00;
    assign is_mem = (commit.kind == exc_pkg::load) || (commit.kind == exc_pkg::store);

    always_comb begin
        case (commit.mem_size)
            2'd0:    data_misaligned = 1'b0;
            2'd1:    data_misaligned = commit.mem_addr[0];
            default: data_misaligned = commit.mem_addr[1:0] != 2'b00;
        endcase
    end

    // highest priority first
    always_comb begin
        exc_hit = 1'b1;
        exc_code = `CODE_INT;
        exc_badvaddr = commit.pc;
        if (int_pending) begin
            exc_code = `CODE_INT;
        end else if (pc_misaligned) begin
            exc_code = `CODE_ADEL;
        end else if (commit.kind == exc_pkg::reserved) begin
            exc_code = `CODE_RI;
        end else if (commit.kind == exc_pkg::syscall) begin
            exc_code = `CODE_SYS;
        end else if (commit.kind == exc_pkg::break_op) begin
            exc_code = `CODE_BP;
        end else if (commit.overflow) begin
            exc_code = `CODE_OV;
        end else if (is_mem && data_misaligned) begin
            exc_code = (commit.kind == exc_pkg::load) ? `CODE_ADEL : `CODE_ADES;
            exc_badvaddr = commit.mem_addr;
        end else begin
            exc_hit = 1'b0;
        end
    end

    assign exception = '{valid:         fire && exc_hit,
                         code:          exc_code,
                         pc:            commit.pc,
                         in_delay_slot: commit.in_delay_slot,
                         badvaddr:      exc_badvaddr};

    assign eret_take = fire && !exc_hit && (commit.kind == exc_pkg::eret);

    assign cp0_we = fire && !exc_hit && (commit.kind == exc_pkg::mtc0);
    assign cp0_wa = commit.cp0_addr;
    assign cp0_wd = commit.wdata;

    assign redirect_take = (fire && exc_hit) || eret_take;

    // ready drops for the flush bubble while redirect is out
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            ready_q <= 1'b0;
            redirect_valid_q <= 1'b0;
        end else begin
            ready_q <= !redirect_take;
            redirect_valid_q <= redirect_take;
        end
    end

    // eret returns to epc as it was before this edge
    always_ff @(posedge clk) begin
        if (redirect_take) begin
            redirect_target_q <= exc_hit ? `EXC_VECTOR : cp0.epc;
        end
    end

    assign commit_ready = ready_q;
    assign redirect = '{valid: redirect_valid_q, target: redirect_target_q};

endmodule

/* src/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// cp0 register numbers, select 0
`define CP0_BADVADDR 5'd8
`define CP0_COUNT    5'd9
`define CP0_COMPARE  5'd11
`define CP0_STATUS   5'd12
`define CP0_CAUSE    5'd13
`define CP0_EPC      5'd14
`define CP0_CONFIG   5'd16

// cause.exccode values
`define CODE_INT  5'd0
`define CODE_ADEL 5'd4
`define CODE_ADES 5'd5
`define CODE_SYS  5'd8
`define CODE_BP   5'd9
`define CODE_RI   5'd10
`define CODE_OV   5'd12

// general exception vector with bev set
`define EXC_VECTOR 32'hBFC0_0380

// m bit set, little endian, mips32 release 1, no mmu
`define CONFIG_RESET 32'h8000_0000

// bev and erl set out of reset
`define STATUS_RESET 32'h0040_0004

// far from count at reset, so no timer interrupt right away
`define COMPARE_RESET 32'hFFFF_FFFF

`endif

/* tests/cp0_patterns.txt */
# pc ds kind mem_addr size ovf cp0 wdata hw_int | redir_valid redir_target | rd_addr rd_expected
# kind: 0 normal 1 load 2 store 3 syscall 4 break 5 eret 6 mtc0 7 reserved, all fields hex
00400000 0 0 00000000 0 0 00 00000000 00 0 00000000 0c 00400004
00400004 0 6 00000000 0 0 0c fffffffc 00 0 00000000 0c 0040ff04
00400008 0 6 00000000 0 0 0e 12345678 00 0 00000000 0e 12345678
0040000c 0 6 00000000 0 0 0b 00f00000 00 0 00000000 0b 00f00000
00400010 0 0 00000000 0 0 00 00000000 00 0 00000000 1f 00000000
00400014 0 5 00000000 0 0 00 00000000 00 1 12345678 0c 0040ff00
00400100 0 3 00000000 0 0 00 00000000 00 1 bfc00380 0e 00400100
00400104 0 5 00000000 0 0 00 00000000 00 1 00400100 0c 0040ff00
00400204 1 4 00000000 0 0 00 00000000 00 1 bfc00380 0d 80000024
00400300 0 7 00000000 0 0 00 00000000 00 1 bfc00380 0e 00400200
00400304 0 5 00000000 0 0 00 00000000 00 1 00400200 0c 0040ff00
00400400 0 0 00000000 0 1 00 00000000 00 1 bfc00380 0d 00000030
00400404 0 5 00000000 0 0 00 00000000 00 1 00400400 0c 0040ff00
00400500 0 1 10000002 2 0 00 00000000 00 1 bfc00380 08 10000002
00400504 0 5 00000000 0 0 00 00000000 00 1 00400500 0d 00000010
00400600 0 2 20000001 1 0 00 00000000 00 1 bfc00380 08 20000001
00400604 0 5 00000000 0 0 00 00000000 00 1 00400600 0d 00000014
00400700 0 2 20000002 1 0 00 00000000 00 0 00000000 08 20000001
00400802 0 0 00000000 0 0 00 00000000 00 1 bfc00380 08 00400802
00400804 0 5 00000000 0 0 00 00000000 00 1 00400802 0c 0040ff00
00400808 0 6 00000000 0 0 0c 0000ff01 00 0 00000000 0c 0040ff01
00400900 0 6 00000000 0 0 0e deadbeef 01 1 bfc00380 0e 00400900
00400904 0 5 00000000 0 0 00 00000000 00 1 00400900 0d 00000000
00400908 0 6 00000000 0 0 0c 00000000 00 0 00000000 0c 00400000
0040090c 0 0 00000000 0 0 00 00000000 00 0 00000000 10 80000000

/* tests/cp0_subsys_chk.sv */
`timescale 1ns/1ps

module cp0_subsys_chk (
    input  logic               clk,
    input  logic               reset,
    input  logic               commit_valid,
    input  logic               commit_ready,
    input  exc_pkg::commit_t   commit,
    input  exc_pkg::redirect_t redirect
);

    // producer holds the item until the transfer
    property commit_held;
        @(posedge clk) disable iff (reset)
            commit_valid && !commit_ready |=> commit_valid && $stable(commit);
    endproperty

    property redirect_single;
        @(posedge clk) disable iff (reset)
            redirect.valid |=> !redirect.valid;
    endproperty

    // one-cycle flush bubble lines up with the redirect pulse
    property bubble_on_redirect;
        @(posedge clk) disable iff (reset)
            redirect.valid |-> !commit_ready ##1 commit_ready;
    endproperty

    a_commit_held: assert property (commit_held)
        else $error("commit dropped or changed before transfer");
    a_redirect_single: assert property (redirect_single)
        else $error("redirect valid held for two cycles");
    a_bubble: assert property (bubble_on_redirect)
        else $error("flush bubble around redirect is not exactly one cycle");

endmodule

bind cp0_subsys cp0_subsys_chk u_cp0_subsys_chk (
    .clk          (clk),
    .reset        (reset),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit       (commit),
    .redirect     (redirect)
);

/* tests/tb_cp0_subsys.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module tb_cp0_subsys;

    typedef struct packed {
        exc_pkg::commit_t   c;
        logic [5:0]         hw;
        logic               rv;
        cp0_pkg::word_t     rt;
        cp0_pkg::cp0_addr_t ra;
        cp0_pkg::word_t     rd;
    } pattern_t;

    logic               clk;
    logic               reset;
    logic               commit_valid;
    logic               commit_ready;
    exc_pkg::commit_t   commit;
    logic [5:0]         hw_int;
    cp0_pkg::cp0_addr_t rd_addr;
    cp0_pkg::word_t     rd_data;
    exc_pkg::redirect_t redirect;
    logic               timer_irq;

    pattern_t    items[$];
    logic [31:0] lcg_state = 32'd3385;
    int          cycles = 0;
    int          cycle_limit = 1000;

    cp0_subsys u_cp0_subsys (
        .clk          (clk),
        .reset        (reset),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit),
        .hw_int       (hw_int),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .redirect     (redirect),
        .timer_irq    (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check(input cp0_pkg::word_t got, input cp0_pkg::word_t exp,
                         input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [13];
        pattern_t    p;
        fd = $fopen("tests/cp0_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file tests/cp0_patterns.txt");
            $display("Test FAILED");
            $fatal(1, "missing pattern file");
        end else begin
            while ($fgets(line, fd)) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                            f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                            f[11], f[12]);
                // comment lines match nothing
                if (n == 13) begin
                    p.c.pc            = f[0];
                    p.c.in_delay_slot = f[1][0];
                    p.c.kind          = exc_pkg::instr_kind_t'(f[2][2:0]);
                    p.c.mem_addr      = f[3];
                    p.c.mem_size      = f[4][1:0];
                    p.c.overflow      = f[5][0];
                    p.c.cp0_addr      = f[6][4:0];
                    p.c.wdata         = f[7];
                    p.hw              = f[8][5:0];
                    p.rv              = f[9][0];
                    p.rt              = f[10];
                    p.ra              = f[11][4:0];
                    p.rd              = f[12];
                    items.push_back(p);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic read_cp0(input cp0_pkg::cp0_addr_t addr, output cp0_pkg::word_t data);
        @(posedge clk);
        rd_addr <= addr;
        @(negedge clk);
        data = rd_data;
    endtask

    task automatic run_item(input pattern_t p, input int idx);
        cp0_pkg::word_t got;
        int             gap;
        @(posedge clk);
        lcg_state = lcg_next(lcg_state);
        gap = lcg_state[17:16];
        repeat (gap) @(posedge clk);
        // two sync stages, then the item commits
        hw_int <= p.hw;
        repeat (2) @(posedge clk);
        commit_valid <= 1'b1;
        commit <= p.c;
        @(negedge clk);
        while (!commit_ready) @(negedge clk);
        @(posedge clk);
        commit_valid <= 1'b0;
        @(negedge clk);
        check({31'b0, redirect.valid}, {31'b0, p.rv}, $sformatf("item %0d redirect valid", idx));
        // flush bubble only after a redirecting transfer
        check({31'b0, commit_ready}, {31'b0, ~p.rv},
              $sformatf("item %0d commit ready after transfer", idx));
        if (p.rv) begin
            check(redirect.target, p.rt, $sformatf("item %0d redirect target", idx));
        end
        read_cp0(p.ra, got);
        check(got, p.rd, $sformatf("item %0d mfc0 read of reg %0d", idx, p.ra));
    endtask

    task automatic timer_test();
        cp0_pkg::word_t count_now;
        cp0_pkg::word_t cause_now;
        pattern_t       p;
        int             waited;
        read_cp0(`CP0_COUNT, count_now);
        p = '0;
        p.c.pc       = 32'h0040_0b00;
        p.c.kind     = exc_pkg::mtc0;
        p.c.cp0_addr = `CP0_COMPARE;
        p.c.wdata    = count_now + 32'd8;
        p.ra         = `CP0_COMPARE;
        p.rd         = count_now + 32'd8;
        run_item(p, items.size());
        waited = 0;
        while (!timer_irq && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        check({31'b0, timer_irq}, 32'd1, "timer_irq rise after compare write");
        read_cp0(`CP0_CAUSE, cause_now);
        check({31'b0, cause_now[15]}, 32'd1, "cause ip7 set by timer");
        // far ahead of count, clears the pending timer
        p.c.pc    = 32'h0040_0b04;
        p.c.wdata = count_now + 32'h1000;
        p.rd      = count_now + 32'h1000;
        run_item(p, items.size() + 1);
        read_cp0(`CP0_CAUSE, cause_now);
        check({31'b0, cause_now[15]}, 32'd0, "cause ip7 cleared by compare write");
    endtask

    initial begin
        reset = 1'b1;
        commit_valid = 1'b0;
        commit = '0;
        hw_int = '0;
        rd_addr = '0;
        load_patterns();
        check(items.size(), 32'd25, "pattern items loaded");
        cycle_limit = items.size() * (4 + 6) + 60;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        foreach (items[i]) begin
            run_item(items[i], i);
        end
        timer_test();
        $display("Test OK");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+src
src/cp0_pkg.sv
src/exc_pkg.sv
src/cp0_regs.sv
src/exc_unit.sv
src/cp0_subsys.sv
tests/cp0_subsys_chk.sv
tests/tb_cp0_subsys.sv
